// File: list.f
source/periph_pkg.sv
source/timer_reg_if.sv
source/ref_clk_edge_detect.sv
source/apb_periph_decoder.sv
source/tick_timer_channel.sv
source/fc_event_mux.sv
source/periph_event_top.sv
verif/tb_periph_event_top.sv

// File: source/apb_periph_decoder.sv
// APB slave for the timer bank: decodes the address, fans writes out and muxes read data back
`timescale 1ns/10ps
`default_nettype none

module apb_periph_decoder (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  periph_pkg::apb_addr_t paddr_i,
    input  periph_pkg::apb_data_t pwdata_i,
    input  logic                  pwrite_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    output periph_pkg::apb_data_t prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,

    timer_reg_if.mgr              tmr_o [periph_pkg::N_TIMER_CH]
);

    import periph_pkg::*;

    ch_idx_t   ch_idx;
    reg_idx_t  reg_idx;
    logic      access;
    logic      addr_err;
    logic      idx_err;
    logic      wr_cnt_err;
    logic      err;
    logic      rd_ok;
    apb_data_t rd_data [N_TIMER_CH];

    ////////////////////////////////////////////////////////////
    // Address split and error flags
    ////////////////////////////////////////////////////////////
    assign ch_idx  = paddr_i[5:4];
    assign reg_idx = paddr_i[3:2];

    assign addr_err   = (paddr_i >= TIMER_SPACE_END);
    assign idx_err    = (reg_idx == 2'd3);
    // COUNT is read only
    assign wr_cnt_err = pwrite_i && (reg_idx == REG_COUNT);
    assign err        = addr_err | idx_err | wr_cnt_err;

    // No wait states, every access cycle completes
    assign access   = psel_i & penable_i;
    assign pready_o = access;

    ////////////////////////////////////////////////////////////
    // Per-channel fan-out
    ////////////////////////////////////////////////////////////
    for (genvar g = 0; g < N_TIMER_CH; g++) begin : g_fanout
        assign tmr_o[g].sel   = access && !err && (ch_idx == ch_idx_t'(g));
        assign tmr_o[g].we    = access && !err && (ch_idx == ch_idx_t'(g)) && pwrite_i;
        assign tmr_o[g].idx   = reg_idx;
        assign tmr_o[g].wdata = pwdata_i;
        assign rd_data[g]     = tmr_o[g].rdata;
    end

    ////////////////////////////////////////////////////////////
    // Response
    ////////////////////////////////////////////////////////////
    assign rd_ok     = access && !err && !pwrite_i;
    assign prdata_o  = rd_ok ? rd_data[ch_idx] : '0;
    assign pslverr_o = access & err;

    a_penable_needs_psel : assert property (
        @(posedge clk_i) disable iff (!rst_ni) penable_i |-> psel_i
    );

    // Setup is followed by access with the same address
    a_paddr_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (psel_i && !penable_i) |=> $stable(paddr_i)
    );

endmodule : apb_periph_decoder

`default_nettype wire

// File: source/fc_event_mux.sv
// Packs timer, reference-edge and external events into the registered fabric-controller event word
`timescale 1ns/10ps
`default_nettype none

module fc_event_mux (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic [periph_pkg::N_TIMER_CH-1:0]   timer_evt_i,
    input  logic                                ref_rise_i,
    input  logic                                ref_fall_i,

    input  logic                                dma_pe_evt_i,
    input  logic                                dma_pe_irq_i,
    input  logic                                pf_evt_i,

    output periph_pkg::fc_events_t              fc_events_o
);

    import periph_pkg::*;

    fc_events_t evt_d;
    fc_events_t evt_q;

    ////////////////////////////////////////////////////////////
    // Fixed bit mapping
    ////////////////////////////////////////////////////////////
    always_comb begin
        // Unmapped positions stay at zero
        evt_d = '0;

        evt_d[EVT_DMA_PE]  = dma_pe_evt_i;
        evt_d[EVT_DMA_IRQ] = dma_pe_irq_i;
        evt_d[EVT_PF]      = pf_evt_i;

        // Either edge of the reference clock
        evt_d[EVT_REF_EDGE] = ref_rise_i | ref_fall_i;

        evt_d[EVT_TIMER_BASE +: N_TIMER_CH] = timer_evt_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            evt_q <= '0;
        end else begin
            evt_q <= evt_d;
        end
    end

    assign fc_events_o = evt_q;

endmodule : fc_event_mux

`default_nettype wire

// File: source/periph_event_top.sv
// Top of the peripheral event subsystem, APB timer bank plus event word for the fabric controller
`timescale 1ns/10ps
`default_nettype none

module periph_event_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    input  logic                   slow_clk_i,

    // APB slave
    input  periph_pkg::apb_addr_t  paddr_i,
    input  periph_pkg::apb_data_t  pwdata_i,
    input  logic                   pwrite_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    output periph_pkg::apb_data_t  prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,

    // External events
    input  logic                   dma_pe_evt_i,
    input  logic                   dma_pe_irq_i,
    input  logic                   pf_evt_i,

    output periph_pkg::fc_events_t fc_events_o
);

    import periph_pkg::*;

    logic                  ref_rise;
    logic                  ref_fall;
    logic [N_TIMER_CH-1:0] timer_evt;

    timer_reg_if tmr_if [N_TIMER_CH] ();

    apb_periph_decoder u_decoder (
        .clk_i     ( clk_i     ),
        .rst_ni    ( rst_ni    ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .pwrite_i  ( pwrite_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .tmr_o     ( tmr_if    )
    );

    ref_clk_edge_detect u_ref_edge (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .slow_clk_i ( slow_clk_i ),
        .rise_o     ( ref_rise   ),
        .fall_o     ( ref_fall   )
    );

    // Timers all count rising edges of the reference clock
    for (genvar g = 0; g < N_TIMER_CH; g++) begin : g_timer
        tick_timer_channel u_timer (
            .clk_i   ( clk_i        ),
            .rst_ni  ( rst_ni       ),
            .tick_i  ( ref_rise     ),
            .regs    ( tmr_if[g]    ),
            .event_o ( timer_evt[g] )
        );
    end

    fc_event_mux u_evt_mux (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .timer_evt_i  ( timer_evt    ),
        .ref_rise_i   ( ref_rise     ),
        .ref_fall_i   ( ref_fall     ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule : periph_event_top

`default_nettype wire

// File: source/periph_pkg.sv
// Shared address map, widths, event positions and types for the peripheral event subsystem
`default_nettype none

package periph_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths and channel count
    ////////////////////////////////////////////////////////////
    localparam int unsigned APB_ADDR_W = 12;
    localparam int unsigned APB_DATA_W = 32;
    localparam int unsigned N_TIMER_CH = 4;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [15:0]           tmr_count_t;

    // Address bits 3:2 pick the register, 5:4 the channel
    typedef logic [1:0]            reg_idx_t;
    typedef logic [1:0]            ch_idx_t;

    typedef logic [31:0]           fc_events_t;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////
    localparam reg_idx_t REG_CTRL    = 2'd0;
    localparam reg_idx_t REG_COMPARE = 2'd1;
    localparam reg_idx_t REG_COUNT   = 2'd2;

    localparam int unsigned CTRL_EN_BIT   = 0;
    localparam int unsigned CTRL_CONT_BIT = 1;

    // Everything from here up decodes as unmapped
    localparam apb_addr_t TIMER_SPACE_END = 12'h040;

    ////////////////////////////////////////////////////////////
    // Fabric-controller event word positions
    ////////////////////////////////////////////////////////////
    localparam int unsigned EVT_DMA_PE     = 8;
    localparam int unsigned EVT_DMA_IRQ    = 9;
    localparam int unsigned EVT_PF         = 12;
    localparam int unsigned EVT_REF_EDGE   = 14;
    // Timer channels occupy four bits upward from here
    localparam int unsigned EVT_TIMER_BASE = 17;

endpackage : periph_pkg

`default_nettype wire

// File: source/ref_clk_edge_detect.sv
// Brings the slow reference clock into clk_i and flags its rising and falling edges as pulses
`timescale 1ns/10ps
`default_nettype none

module ref_clk_edge_detect (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic slow_clk_i,
    output logic rise_o,
    output logic fall_o
);

    // Two metastability stages, then one of history
    logic [1:0] sync_q;
    logic       hist_q;
    logic       rise_q;
    logic       fall_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q <= '0;
            hist_q <= 1'b0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], slow_clk_i};
            hist_q <= sync_q[1];
            // Registered pulses land three cycles after the input moves
            rise_q <= sync_q[1] & ~hist_q;
            fall_q <= ~sync_q[1] & hist_q;
        end
    end

    assign rise_o = rise_q;
    assign fall_o = fall_q;

    // Each input edge shows up as a pulse three cycles later
    a_rise_latency : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $rose(slow_clk_i) |-> ##3 rise_o
    );

    a_fall_latency : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $fell(slow_clk_i) |-> ##3 fall_o
    );

endmodule : ref_clk_edge_detect

`default_nettype wire

// File: source/tick_timer_channel.sv
// One tick timer: counts reference ticks up to COMPARE and fires a one-cycle event on match
`timescale 1ns/10ps
`default_nettype none

module tick_timer_channel (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     tick_i,
    timer_reg_if.sub regs,
    output logic     event_o
);

    import periph_pkg::*;

    typedef enum logic {
        TMR_IDLE,
        TMR_RUN
    } tmr_state_e;

    tmr_state_e state_q;
    logic       ctrl_en_q;
    logic       ctrl_cont_q;
    tmr_count_t compare_q;
    tmr_count_t count_q;
    logic       event_q;

    logic       wr;
    logic       wr_ctrl;
    logic       wr_compare;
    logic       hit;

    assign wr         = regs.sel & regs.we;
    assign wr_ctrl    = wr && (regs.idx == REG_CTRL);
    assign wr_compare = wr && (regs.idx == REG_COMPARE);

    // Terminal count reached on this tick
    assign hit = tick_i && (state_q == TMR_RUN) && (count_q == compare_q);

    ////////////////////////////////////////////////////////////
    // Counter and run state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= TMR_IDLE;
            ctrl_en_q   <= 1'b0;
            ctrl_cont_q <= 1'b0;
            compare_q   <= '0;
            count_q     <= '0;
            event_q     <= 1'b0;
        end else begin
            event_q <= hit;

            if (tick_i && state_q == TMR_RUN) begin
                if (hit) begin
                    count_q <= '0;
                    // One-shot stops after its single event
                    if (!ctrl_cont_q) begin
                        ctrl_en_q <= 1'b0;
                        state_q   <= TMR_IDLE;
                    end
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end

            // Bus writes take priority over the tick
            if (wr_ctrl) begin
                ctrl_en_q   <= regs.wdata[CTRL_EN_BIT];
                ctrl_cont_q <= regs.wdata[CTRL_CONT_BIT];
                if (regs.wdata[CTRL_EN_BIT]) begin
                    count_q <= '0;
                    state_q <= TMR_RUN;
                end else begin
                    state_q <= TMR_IDLE;
                end
            end

            if (wr_compare) begin
                compare_q <= regs.wdata[15:0];
            end
        end
    end

    assign event_o = event_q;

    ////////////////////////////////////////////////////////////
    // Read back
    ////////////////////////////////////////////////////////////
    always_comb begin
        regs.rdata = '0;
        case (regs.idx)
            REG_CTRL: begin
                regs.rdata[CTRL_EN_BIT]   = ctrl_en_q;
                regs.rdata[CTRL_CONT_BIT] = ctrl_cont_q;
            end
            REG_COMPARE: regs.rdata[15:0] = compare_q;
            REG_COUNT:   regs.rdata[15:0] = count_q;
            default:     regs.rdata = '0;
        endcase
    end

    // Ticks are never back to back, so neither are events
    a_event_single : assert property (
        @(posedge clk_i) disable iff (!rst_ni) event_o |=> !event_o
    );

endmodule : tick_timer_channel

`default_nettype wire

// File: source/timer_reg_if.sv
// Register-access bundle from the APB decoder to one timer channel, one instance per channel
`timescale 1ns/10ps
`default_nettype none

interface timer_reg_if;

    import periph_pkg::*;

    // Access strobe, only in the access cycle of a good transfer
    logic      sel;
    logic      we;
    reg_idx_t  idx;
    apb_data_t wdata;
    // Combinational read data from the channel
    apb_data_t rdata;

    modport mgr (
        output sel,
        output we,
        output idx,
        output wdata,
        input  rdata
    );

    modport sub (
        input  sel,
        input  we,
        input  idx,
        input  wdata,
        output rdata
    );

endinterface : timer_reg_if

`default_nettype wire

// File: verif/tb_periph_event_top.sv
// Self-checking testbench for periph_event_top, random APB and slow-clock stimulus against a model
`timescale 1ns/10ps
`default_nettype none

module tb_periph_event_top;

    import periph_pkg::*;

    localparam int unsigned SEED = 17395;
    // Worst case slow edges over the timer and reference tests, APB transfers, other cycles
    localparam int unsigned EDGE_BUDGET = 98;
    localparam int unsigned APB_BUDGET  = 100;
    localparam int unsigned MISC_BUDGET = 120;
    localparam int unsigned TIMEOUT_CYCLES = 2 * (EDGE_BUDGET * 4 + APB_BUDGET * 3 + MISC_BUDGET);

    localparam fc_events_t EXT_MASK = (fc_events_t'(1) << EVT_DMA_PE)
                                    | (fc_events_t'(1) << EVT_DMA_IRQ)
                                    | (fc_events_t'(1) << EVT_PF);
    localparam fc_events_t MAPPED_MASK = EXT_MASK | (fc_events_t'(1) << EVT_REF_EDGE)
                                       | (fc_events_t'(32'hf) << EVT_TIMER_BASE);

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       slow_clk_i;
    apb_addr_t  paddr_i;
    apb_data_t  pwdata_i;
    logic       pwrite_i;
    logic       psel_i;
    logic       penable_i;
    apb_data_t  prdata_o;
    logic       pready_o;
    logic       pslverr_o;
    logic       dma_pe_evt_i;
    logic       dma_pe_irq_i;
    logic       pf_evt_i;
    fc_events_t fc_events_o;

    // Reference model state per channel
    logic [1:0]  m_ctrl [N_TIMER_CH];
    tmr_count_t  m_cmp [N_TIMER_CH];
    tmr_count_t  m_cnt [N_TIMER_CH];
    int unsigned m_evt [N_TIMER_CH];

    int unsigned tmr_seen [N_TIMER_CH];
    int unsigned ref_seen = 0;
    int unsigned cycles = 0;
    fc_events_t  ext_exp = '0;
    string       test_name = "reset";

    periph_event_top u_dut (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .slow_clk_i   ( slow_clk_i   ),
        .paddr_i      ( paddr_i      ),
        .pwdata_i     ( pwdata_i     ),
        .pwrite_i     ( pwrite_i     ),
        .psel_i       ( psel_i       ),
        .penable_i    ( penable_i    ),
        .prdata_o     ( prdata_o     ),
        .pready_o     ( pready_o     ),
        .pslverr_o    ( pslverr_o    ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .fc_events_o  ( fc_events_o  )
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run took more than %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_data(input string what, input apb_data_t exp, input apb_data_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_count(input string what, input tmr_count_t exp, input tmr_count_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "Count mismatch");
        end
    endtask

    task automatic check_events(input string what, input fc_events_t exp, input fc_events_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "Event word mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "Flag mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Event monitors
    ////////////////////////////////////////////////////////////
    // External inputs seen at this edge must show up in the word one cycle later
    always @(posedge clk_i) begin
        ext_exp <= (fc_events_t'(dma_pe_evt_i) << EVT_DMA_PE)
                 | (fc_events_t'(dma_pe_irq_i) << EVT_DMA_IRQ)
                 | (fc_events_t'(pf_evt_i) << EVT_PF);
    end

    always @(negedge clk_i) begin
        if (rst_ni) begin
            check_events("unmapped_bits", '0, fc_events_o & ~MAPPED_MASK);
            check_events("external_bits", ext_exp, fc_events_o & EXT_MASK);
            if (fc_events_o[EVT_REF_EDGE]) ref_seen++;
            for (int i = 0; i < N_TIMER_CH; i++) begin
                if (fc_events_o[EVT_TIMER_BASE + i]) tmr_seen[i]++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Model, stimulus and APB tasks
    ////////////////////////////////////////////////////////////
    task automatic model_tick();
        for (int ch = 0; ch < N_TIMER_CH; ch++) begin
            if (m_ctrl[ch][CTRL_EN_BIT]) begin
                if (m_cnt[ch] == m_cmp[ch]) begin
                    m_evt[ch]++;
                    m_cnt[ch] = '0;
                    if (!m_ctrl[ch][CTRL_CONT_BIT]) m_ctrl[ch][CTRL_EN_BIT] = 1'b0;
                end else begin
                    m_cnt[ch] = m_cnt[ch] + 1'b1;
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #10;
    endtask

    // One slow-clock edge every four clk_i cycles
    task automatic toggle_slow(input int unsigned n_edges);
        repeat (n_edges) begin
            slow_clk_i = ~slow_clk_i;
            if (slow_clk_i) model_tick();
            repeat (4) next_cycle();
        end
    endtask

    task automatic settle();
        repeat (8) next_cycle();
    endtask

    function automatic apb_addr_t reg_addr(input int unsigned ch, input reg_idx_t idx);
        return apb_addr_t'({ch_idx_t'(ch), idx, 2'b00});
    endfunction

    function automatic logic xfer_error(input apb_addr_t addr, input logic wr);
        return (addr >= TIMER_SPACE_END) || (addr[3:2] == 2'd3)
            || (wr && addr[3:2] == REG_COUNT);
    endfunction

    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                            output apb_data_t rdata);
        logic exp_err;
        exp_err   = xfer_error(addr, wr);
        paddr_i   = addr;
        pwrite_i  = wr;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        next_cycle();
        penable_i = 1'b1;
        @(negedge clk_i);
        check_flag("pready", 1'b1, pready_o);
        check_flag("pslverr", exp_err, pslverr_o);
        if (exp_err) check_data("error_prdata", '0, prdata_o);
        rdata = prdata_o;
        next_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        // Accepted writes land in the model at the same edge as in the DUT
        if (wr && !exp_err) begin
            case (addr[3:2])
                REG_CTRL: begin
                    m_ctrl[addr[5:4]] = wdata[1:0];
                    if (wdata[CTRL_EN_BIT]) m_cnt[addr[5:4]] = '0;
                end
                REG_COMPARE: m_cmp[addr[5:4]] = wdata[15:0];
                default: ;
            endcase
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        apb_xfer(addr, 1'b1, data, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        apb_xfer(addr, 1'b0, '0, data);
    endtask

    task automatic check_channel(input int unsigned ch);
        apb_data_t rd;
        apb_read(reg_addr(ch, REG_CTRL), rd);
        check_data("ctrl", apb_data_t'(m_ctrl[ch]), rd);
        apb_read(reg_addr(ch, REG_COMPARE), rd);
        check_data("compare", apb_data_t'(m_cmp[ch]), rd);
        apb_read(reg_addr(ch, REG_COUNT), rd);
        check_data("count", apb_data_t'(m_cnt[ch]), rd);
        check_count("event_total", tmr_count_t'(m_evt[ch]), tmr_count_t'(tmr_seen[ch]));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int unsigned seed_ret;
        int unsigned ch;
        int unsigned n;
        int unsigned m;
        int unsigned k;
        int unsigned base;
        int unsigned cmp_n [N_TIMER_CH];
        int unsigned base_evt [N_TIMER_CH];
        apb_data_t   rd;

        rst_ni       = 1'b0;
        slow_clk_i   = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        pwrite_i     = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b0;
        for (int i = 0; i < N_TIMER_CH; i++) begin
            m_ctrl[i]   = '0;
            m_cmp[i]    = '0;
            m_cnt[i]    = '0;
            m_evt[i]    = 0;
            tmr_seen[i] = 0;
        end
        seed_ret = $urandom(SEED);
        repeat (8) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        next_cycle();

        test_name = "register_access";
        for (int i = 0; i < N_TIMER_CH; i++) begin
            apb_write(reg_addr(i, REG_CTRL), $urandom & ~32'h1);
            apb_write(reg_addr(i, REG_COMPARE), $urandom);
            check_channel(i);
        end

        test_name = "error_response";
        repeat (6) begin
            apb_write((apb_addr_t'(12'h040 + ($urandom % 12'hfc0))) & 12'hffc, $urandom);
            apb_read((apb_addr_t'(12'h040 + ($urandom % 12'hfc0))) & 12'hffc, rd);
        end
        for (int i = 0; i < N_TIMER_CH; i++) begin
            apb_read(reg_addr(i, 2'd3), rd);
            apb_write(reg_addr(i, 2'd3), $urandom);
            apb_write(reg_addr(i, REG_COUNT), $urandom);
        end
        // Rejected writes must leave every register untouched
        for (int i = 0; i < N_TIMER_CH; i++) check_channel(i);

        test_name = "one_shot";
        ch   = $urandom % N_TIMER_CH;
        n    = $urandom % 6;
        base = tmr_seen[ch];
        apb_write(reg_addr(ch, REG_COMPARE), n);
        apb_write(reg_addr(ch, REG_CTRL), 32'h1);
        toggle_slow(2 * (n + 1 + 1 + ($urandom % 3)));
        settle();
        check_count("single_event", 1, tmr_count_t'(tmr_seen[ch] - base));
        for (int i = 0; i < N_TIMER_CH; i++) check_channel(i);

        test_name = "continuous";
        m = 10 + ($urandom % 21);
        for (int i = 0; i < N_TIMER_CH; i++) begin
            cmp_n[i]    = $urandom % 6;
            base_evt[i] = tmr_seen[i];
            apb_write(reg_addr(i, REG_COMPARE), cmp_n[i]);
            apb_write(reg_addr(i, REG_CTRL), 32'h3);
        end
        toggle_slow(2 * m);
        settle();
        for (int i = 0; i < N_TIMER_CH; i++) begin
            check_count("events", m / (cmp_n[i] + 1), tmr_count_t'(tmr_seen[i] - base_evt[i]));
            apb_read(reg_addr(i, REG_COUNT), rd);
            check_count("count_left", m % (cmp_n[i] + 1), rd[15:0]);
            check_channel(i);
            apb_write(reg_addr(i, REG_CTRL), 32'h0);
        end

        test_name = "reference_edges";
        k    = 1 + ($urandom % 20);
        base = ref_seen;
        toggle_slow(k);
        settle();
        check_count("edge_pulses", k, tmr_count_t'(ref_seen - base));

        test_name = "external_events";
        repeat (64) begin
            dma_pe_evt_i = $urandom;
            dma_pe_irq_i = $urandom;
            pf_evt_i     = $urandom;
            next_cycle();
        end
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b0;
        repeat (2) next_cycle();

        $display("Simulation PASSED");
        $finish;
    end

endmodule : tb_periph_event_top

`default_nettype wire
